/* Makefile */
TOP = riscv_lsu_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f all.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -sv --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
hdl/riscv_lsu_pkg.sv
hdl/riscv_lsu_op_decode.sv
hdl/riscv_lsu_reservation.sv
hdl/riscv_lsu_cache_port.sv
hdl/riscv_lsu.sv
test/riscv_lsu_tb.sv

/* hdl/riscv_lsu.sv */
module riscv_lsu
  import riscv_lsu_pkg::*;
(
  input  logic            i_riscv_lsu_clk,
  input  logic            i_riscv_lsu_rst,
  input  logic            i_riscv_lsu_globstall,
  input  logic [xlen-1:0] i_riscv_lsu_address,      // rs1
  input  logic [xlen-1:0] i_riscv_lsu_alu_result,
  input  logic [1:0]      i_riscv_lsu_lr,
  input  logic [1:0]      i_riscv_lsu_sc,
  input  logic            i_riscv_lsu_amo,
  input  logic            i_riscv_lsu_memwrite,
  input  logic            i_riscv_lsu_memread,
  input  logic            i_riscv_lsu_goto_trap,
  input  logic            i_riscv_lsu_return_trap,
  input  logic            i_riscv_lsu_misalignment,
  output logic            o_riscv_lsu_memwrite_en,
  output logic            o_riscv_lsu_memread_en,
  output logic [xlen-1:0] o_riscv_lsu_mem_address,
  output logic [xlen-1:0] o_riscv_lsu_sc_rdvalue
);

  lsu_req_t req;   // decoded request
  lsu_rsv_t rsv;   // sc verdict

  riscv_lsu_op_decode u_op_decode (
    .i_riscv_lsu_clk          (i_riscv_lsu_clk),
    .i_riscv_lsu_rst          (i_riscv_lsu_rst),
    .i_riscv_lsu_address      (i_riscv_lsu_address),
    .i_riscv_lsu_alu_result   (i_riscv_lsu_alu_result),
    .i_riscv_lsu_lr           (i_riscv_lsu_lr),
    .i_riscv_lsu_sc           (i_riscv_lsu_sc),
    .i_riscv_lsu_amo          (i_riscv_lsu_amo),
    .i_riscv_lsu_memwrite     (i_riscv_lsu_memwrite),
    .i_riscv_lsu_memread      (i_riscv_lsu_memread),
    .i_riscv_lsu_goto_trap    (i_riscv_lsu_goto_trap),
    .i_riscv_lsu_return_trap  (i_riscv_lsu_return_trap),
    .i_riscv_lsu_misalignment (i_riscv_lsu_misalignment),
    .o_riscv_lsu_req          (req)
  );

  riscv_lsu_reservation u_reservation (
    .i_riscv_lsu_clk       (i_riscv_lsu_clk),
    .i_riscv_lsu_rst       (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall (i_riscv_lsu_globstall),
    .i_riscv_lsu_req       (req),
    .o_riscv_lsu_rsv       (rsv)
  );

  riscv_lsu_cache_port u_cache_port (
    .i_riscv_lsu_clk         (i_riscv_lsu_clk),
    .i_riscv_lsu_rst         (i_riscv_lsu_rst),
    .i_riscv_lsu_req         (req),
    .i_riscv_lsu_rsv         (rsv),
    .o_riscv_lsu_memread_en  (o_riscv_lsu_memread_en),
    .o_riscv_lsu_memwrite_en (o_riscv_lsu_memwrite_en),
    .o_riscv_lsu_mem_address (o_riscv_lsu_mem_address),
    .o_riscv_lsu_sc_rdvalue  (o_riscv_lsu_sc_rdvalue)
  );

endmodule

/* hdl/riscv_lsu_cache_port.sv */
module riscv_lsu_cache_port
  import riscv_lsu_pkg::*;
(
  input  logic            i_riscv_lsu_clk,          // only samples the assertion
  input  logic            i_riscv_lsu_rst,
  input  lsu_req_t        i_riscv_lsu_req,
  input  lsu_rsv_t        i_riscv_lsu_rsv,
  output logic            o_riscv_lsu_memread_en,
  output logic            o_riscv_lsu_memwrite_en,
  output logic [xlen-1:0] o_riscv_lsu_mem_address,
  output logic [xlen-1:0] o_riscv_lsu_sc_rdvalue
);

  logic live;   // request survives trap and misalignment

  assign live = !i_riscv_lsu_req.kill;

  // data cache strobes and address
  always_comb
  begin
    o_riscv_lsu_memread_en  = 1'b0;
    o_riscv_lsu_memwrite_en = 1'b0;
    o_riscv_lsu_mem_address = i_riscv_lsu_req.addr;
    unique case (i_riscv_lsu_req.op)
      lsu_op_read:
      begin
        o_riscv_lsu_memread_en  = live;
      end
      lsu_op_write:
      begin
        o_riscv_lsu_memwrite_en = live;
      end
      lsu_op_lr:
      begin
        o_riscv_lsu_memread_en  = live;
      end
      lsu_op_sc:
      begin
        // kill already folded into the verdict
        o_riscv_lsu_memwrite_en = i_riscv_lsu_rsv.sc_success;
      end
      lsu_op_amo:
      begin
        o_riscv_lsu_memread_en  = live;   // read half of the atomic
      end
      default:
      begin
        o_riscv_lsu_mem_address = '0;   // idle bus
      end
    endcase
  end

  // rd value, only meaningful for sc
  always_comb
  begin
    if (i_riscv_lsu_req.op == lsu_op_sc)
    begin
      if (i_riscv_lsu_rsv.sc_success)
      begin
        o_riscv_lsu_sc_rdvalue = sc_pass_value;
      end
      else
      begin
        o_riscv_lsu_sc_rdvalue = sc_fail_value;   // killed sc lands here too
      end
    end
    else
    begin
      o_riscv_lsu_sc_rdvalue = sc_pass_value;
    end
  end

  // cache sees at most one strobe per cycle
  rd_wr_exclusive: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
      !(o_riscv_lsu_memread_en && o_riscv_lsu_memwrite_en)
  ) else $error("cache port: read and write enable high together");

endmodule

/* hdl/riscv_lsu_op_decode.sv */
module riscv_lsu_op_decode
  import riscv_lsu_pkg::*;
(
  input  logic            i_riscv_lsu_clk,          // only samples the assertion
  input  logic            i_riscv_lsu_rst,
  input  logic [xlen-1:0] i_riscv_lsu_address,      // rs1
  input  logic [xlen-1:0] i_riscv_lsu_alu_result,
  input  logic [1:0]      i_riscv_lsu_lr,           // [1] lr, [0] double word
  input  logic [1:0]      i_riscv_lsu_sc,           // [1] sc, [0] double word
  input  logic            i_riscv_lsu_amo,
  input  logic            i_riscv_lsu_memwrite,
  input  logic            i_riscv_lsu_memread,
  input  logic            i_riscv_lsu_goto_trap,    // from csr
  input  logic            i_riscv_lsu_return_trap,  // from csr
  input  logic            i_riscv_lsu_misalignment,
  output lsu_req_t        o_riscv_lsu_req
);

  logic [op_sel_w-1:0] op_sel;
  lsu_op_e             op;

  assign op_sel = {i_riscv_lsu_memread,
                   i_riscv_lsu_memwrite,
                   i_riscv_lsu_lr[1],
                   i_riscv_lsu_sc[1],
                   i_riscv_lsu_amo};

  // one hot select, amo may come with memread
  always_comb
  begin
    case (op_sel)
      5'b10000: op = lsu_op_read;
      5'b01000: op = lsu_op_write;
      5'b00100: op = lsu_op_lr;
      5'b00010: op = lsu_op_sc;
      5'b00001: op = lsu_op_amo;
      5'b10001: op = lsu_op_amo;
      default:  op = lsu_op_none;
    endcase
  end

  // address source and width bit per op class
  always_comb
  begin
    o_riscv_lsu_req.op    = op;
    o_riscv_lsu_req.dword = 1'b0;
    o_riscv_lsu_req.addr  = i_riscv_lsu_alu_result;
    // any of these cancels the access in this cycle
    o_riscv_lsu_req.kill  = i_riscv_lsu_goto_trap |
                            i_riscv_lsu_return_trap |
                            i_riscv_lsu_misalignment;
    case (op)
      lsu_op_lr:
      begin
        o_riscv_lsu_req.dword = i_riscv_lsu_lr[0];
        o_riscv_lsu_req.addr  = i_riscv_lsu_address;
      end
      lsu_op_sc:
      begin
        o_riscv_lsu_req.dword = i_riscv_lsu_sc[0];
        o_riscv_lsu_req.addr  = i_riscv_lsu_address;
      end
      lsu_op_amo:
      begin
        o_riscv_lsu_req.addr  = i_riscv_lsu_address;   // atomics address by rs1
      end
      default:
      begin
        o_riscv_lsu_req.addr  = i_riscv_lsu_alu_result;
      end
    endcase
  end

  // the execute stage never raises conflicting selects
  op_sel_legal: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
      $onehot0({i_riscv_lsu_memwrite, i_riscv_lsu_lr[1], i_riscv_lsu_sc[1]}) &&
      (!i_riscv_lsu_memread ||
       !(i_riscv_lsu_memwrite | i_riscv_lsu_lr[1] | i_riscv_lsu_sc[1]))
  ) else $error("op decode: conflicting memory op selects");

endmodule

/* hdl/riscv_lsu_pkg.sv */
package riscv_lsu_pkg;

  // data and address width
  localparam int unsigned xlen = 64;

  // value returned to rd by a store conditional
  localparam logic [xlen-1:0] sc_pass_value = '0;
  localparam logic [xlen-1:0] sc_fail_value = {{(xlen-1){1'b0}}, 1'b1};

  // width of the op select vector {memread, memwrite, lr, sc, amo}
  localparam int unsigned op_sel_w = 5;

  // decoded memory operation
  typedef enum logic [2:0] {
    lsu_op_none  = 3'd0,
    lsu_op_read  = 3'd1,   // normal load
    lsu_op_write = 3'd2,   // normal store
    lsu_op_lr    = 3'd3,   // load reserved
    lsu_op_sc    = 3'd4,   // store conditional
    lsu_op_amo   = 3'd5    // atomic read side
  } lsu_op_e;

  // one decoded request, built by the op decode
  typedef struct packed {
    lsu_op_e          op;
    logic             dword;   // lr/sc width, 1 means double word
    logic [xlen-1:0]  addr;    // alu result or rs1 depending on op
    logic             kill;    // trap entry, trap return or misaligned
  } lsu_req_t;

  // verdict of the reservation tracker
  typedef struct packed {
    logic sc_success;
  } lsu_rsv_t;

endpackage

/* hdl/riscv_lsu_reservation.sv */
module riscv_lsu_reservation
  import riscv_lsu_pkg::*;
(
  input  logic      i_riscv_lsu_clk,
  input  logic      i_riscv_lsu_rst,
  input  logic      i_riscv_lsu_globstall,   // freezes the reservation
  input  lsu_req_t  i_riscv_lsu_req,
  output lsu_rsv_t  o_riscv_lsu_rsv
);

  logic [xlen-1:0] rsv_addr;
  logic            rsv_valid;
  logic            rsv_dword;   // width of the reserving lr
  logic            upd_en;
  logic            is_lr;
  logic            is_sc;
  logic            addr_match;

  assign is_lr      = (i_riscv_lsu_req.op == lsu_op_lr);
  assign is_sc      = (i_riscv_lsu_req.op == lsu_op_sc);
  assign addr_match = (i_riscv_lsu_req.addr == rsv_addr);

  // killed or stalled requests never touch the reservation
  assign upd_en = !i_riscv_lsu_globstall && !i_riscv_lsu_req.kill;

  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      rsv_addr  <= '0;
      rsv_valid <= 1'b0;
      rsv_dword <= 1'b0;
    end
    else if (upd_en)
    begin
      if (is_lr)
      begin
        // new reservation replaces any older one
        rsv_addr  <= i_riscv_lsu_req.addr;
        rsv_valid <= 1'b1;
        rsv_dword <= i_riscv_lsu_req.dword;
      end
      else if (is_sc)
      begin
        // any sc consumes the reservation, pass or fail
        rsv_addr  <= '0;
        rsv_valid <= 1'b0;
      end
    end
  end

  // verdict uses the state before this cycle's update
  always_comb
  begin
    o_riscv_lsu_rsv.sc_success = is_sc &&
                                 rsv_valid &&
                                 addr_match &&
                                 (i_riscv_lsu_req.dword == rsv_dword) &&
                                 !i_riscv_lsu_req.kill;
  end

  // a live sc always leaves the reservation empty
  sc_clears_rsv: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
      (!i_riscv_lsu_globstall && !i_riscv_lsu_req.kill && is_sc) |=> !rsv_valid
  ) else $error("reservation: still valid after store conditional");

  // one reservation pays for one store conditional
  sc_pass_once: assert property (
    @(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
      (o_riscv_lsu_rsv.sc_success && !i_riscv_lsu_globstall) |=> !o_riscv_lsu_rsv.sc_success
  ) else $error("reservation: second sc success without a new lr");

endmodule

/* test/riscv_lsu_tb.sv */
module riscv_lsu_tb
  import riscv_lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles   = 4;
  localparam int test_cycles    = 2000;
  localparam int timeout_cycles = reset_cycles + test_cycles + 96;   // 2100 with margin

  logic            clk;
  logic            rst;
  logic            globstall;
  logic [xlen-1:0] address;
  logic [xlen-1:0] alu_result;
  logic [1:0]      lr;
  logic [1:0]      sc;
  logic            amo;
  logic            memwrite;
  logic            memread;
  logic            goto_trap;
  logic            return_trap;
  logic            misalignment;
  logic            memwrite_en;
  logic            memread_en;
  logic [xlen-1:0] mem_address;
  logic [xlen-1:0] sc_rdvalue;

  // reference reservation
  logic            m_valid;
  logic [xlen-1:0] m_addr;
  logic            m_dword;
  lsu_op_e         cur_op;   // op class picked by the stimulus

  integer seed;
  int     cycle_cnt = 0;
  int     sc_pass_cnt = 0;
  int     sc_fail_cnt = 0;
  int     kill_cnt = 0;

  riscv_lsu uut (
    .i_riscv_lsu_clk          (clk),
    .i_riscv_lsu_rst          (rst),
    .i_riscv_lsu_globstall    (globstall),
    .i_riscv_lsu_address      (address),
    .i_riscv_lsu_alu_result   (alu_result),
    .i_riscv_lsu_lr           (lr),
    .i_riscv_lsu_sc           (sc),
    .i_riscv_lsu_amo          (amo),
    .i_riscv_lsu_memwrite     (memwrite),
    .i_riscv_lsu_memread      (memread),
    .i_riscv_lsu_goto_trap    (goto_trap),
    .i_riscv_lsu_return_trap  (return_trap),
    .i_riscv_lsu_misalignment (misalignment),
    .o_riscv_lsu_memwrite_en  (memwrite_en),
    .o_riscv_lsu_memread_en   (memread_en),
    .o_riscv_lsu_mem_address  (mem_address),
    .o_riscv_lsu_sc_rdvalue   (sc_rdvalue)
  );

  always #20 clk = ~clk;

  // small pool so sc often hits the reservation
  function automatic logic [xlen-1:0] pool_addr(input logic [1:0] idx);
    case (idx)
      2'd0:    return 64'h0000_0000_8000_1000;
      2'd1:    return 64'h0000_0000_8000_1008;
      2'd2:    return 64'h0000_0000_8000_2040;
      default: return 64'hffff_ffc0_0000_0100;
    endcase
  endfunction

  function automatic logic chance(input int unsigned pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  task automatic clear_inputs();
    globstall    = 1'b0;
    address      = '0;
    alu_result   = '0;
    lr           = 2'b00;
    sc           = 2'b00;
    amo          = 1'b0;
    memwrite     = 1'b0;
    memread      = 1'b0;
    goto_trap    = 1'b0;
    return_trap  = 1'b0;
    misalignment = 1'b0;
    cur_op       = lsu_op_none;
  endtask

  task automatic drive_random();
    logic [31:0] rnd;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [3:0]  sel;
    rnd = $random(seed);
    hi  = $random(seed);
    lo  = $random(seed);
    sel = rnd[3:0];
    clear_inputs();
    lr[0]      = rnd[4];   // width bits random whatever the op
    sc[0]      = rnd[5];
    address    = pool_addr(rnd[7:6]);
    alu_result = {hi, lo};
    // atomics weighted up
    if (sel < 4'd2)
      cur_op = lsu_op_none;
    else if (sel < 4'd4)
    begin
      cur_op  = lsu_op_read;
      memread = 1'b1;
    end
    else if (sel < 4'd6)
    begin
      cur_op   = lsu_op_write;
      memwrite = 1'b1;
    end
    else if (sel < 4'd10)
    begin
      cur_op = lsu_op_lr;
      lr[1]  = 1'b1;
    end
    else if (sel < 4'd14)
    begin
      cur_op = lsu_op_sc;
      sc[1]  = 1'b1;
    end
    else
    begin
      cur_op  = lsu_op_amo;
      amo     = 1'b1;
      memread = rnd[8];   // amo comes with or without memread
    end
    globstall    = chance(20);
    goto_trap    = chance(5);
    return_trap  = chance(5);
    misalignment = chance(5);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("MISMATCH %s expected 0x%h actual 0x%h at %0t", name, exp_val, act_val, $time);
    $display("Simulation finished: FAIL");
    $fatal(1, "output mismatch");
  endtask

  task automatic check_outputs();
    logic            kill;
    logic            sc_ok;
    logic            exp_rd_en;
    logic            exp_wr_en;
    logic [xlen-1:0] exp_addr;
    logic [xlen-1:0] exp_rdv;
    kill  = goto_trap | return_trap | misalignment;
    sc_ok = (cur_op == lsu_op_sc) && m_valid && (address == m_addr) &&
            (sc[0] == m_dword) && !kill;
    exp_rd_en = !kill && ((cur_op == lsu_op_read) || (cur_op == lsu_op_lr) ||
                          (cur_op == lsu_op_amo));
    exp_wr_en = (!kill && (cur_op == lsu_op_write)) || sc_ok;
    case (cur_op)
      lsu_op_none:  exp_addr = '0;
      lsu_op_read:  exp_addr = alu_result;
      lsu_op_write: exp_addr = alu_result;
      default:      exp_addr = address;   // atomics use rs1
    endcase
    exp_rdv = ((cur_op == lsu_op_sc) && !sc_ok) ? 64'd1 : 64'd0;

    assert (memread_en === exp_rd_en)
      else report_mismatch("o_riscv_lsu_memread_en", {63'd0, exp_rd_en}, {63'd0, memread_en});
    assert (memwrite_en === exp_wr_en)
      else report_mismatch("o_riscv_lsu_memwrite_en", {63'd0, exp_wr_en},
                           {63'd0, memwrite_en});
    assert (mem_address === exp_addr)
      else report_mismatch("o_riscv_lsu_mem_address", exp_addr, mem_address);
    assert (sc_rdvalue === exp_rdv)
      else report_mismatch("o_riscv_lsu_sc_rdvalue", exp_rdv, sc_rdvalue);

    if (cur_op == lsu_op_sc)
    begin
      if (sc_ok)
        sc_pass_cnt++;
      else
        sc_fail_cnt++;
    end
    if (kill)
      kill_cnt++;
  endtask

  // what the coming edge does to the reservation
  task automatic update_reservation();
    logic kill;
    kill = goto_trap | return_trap | misalignment;
    if (!globstall && !kill)
    begin
      if (cur_op == lsu_op_lr)
      begin
        m_valid = 1'b1;
        m_addr  = address;
        m_dword = lr[0];
      end
      else if (cur_op == lsu_op_sc)
      begin
        m_valid = 1'b0;
        m_addr  = '0;
      end
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("timeout: run did not end within %0d cycles", timeout_cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    seed    = 41376;
    clk     = 1'b0;
    rst     = 1'b1;
    m_valid = 1'b0;
    m_addr  = '0;
    m_dword = 1'b0;
    clear_inputs();
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < test_cycles; i++)
    begin
      @(posedge clk);
      #2;
      drive_random();
      #36;   // just before the next edge
      check_outputs();
      update_reservation();
    end

    if (sc_pass_cnt > 0 && sc_fail_cnt > 0 && kill_cnt > 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      $display("stimulus never hit a passing sc, a failing sc and a kill");
      $display("Simulation finished: FAIL");
      $fatal(1, "incomplete stimulus");
    end
  end

endmodule
